//--- logic/adc_frontend.sv
// ADC front end, captures both converter words and turns them into two's complement
`timescale 1ns/1ns

module adc_frontend (
  input  logic                      adc_clk,
  input  logic                      adc_rstn,
  input  conv_pkg::adc_word_t [1:0] adc_word_i,   // [0] channel A, [1] channel B
  input  logic                      loop_en_i,    // Digital loopback
  input  conv_pkg::ch_pair_t        loop_pair_i,  // Lane results
  output conv_pkg::ch_pair_t        adc_pair_o
);

  //////////////////////////////////////////////////////////////////////
  // Code extraction
  //////////////////////////////////////////////////////////////////////

  conv_pkg::dac_code_t code_a;  // Top 14 bits of word A
  conv_pkg::dac_code_t code_b;  // Top 14 bits of word B
  conv_pkg::ch_pair_t  adc_q;   // Captured samples

  // Drop reserved LSBs
  assign code_a = adc_word_i[0][$bits(conv_pkg::adc_word_t)-1:conv_pkg::ADC_DROP_LSB];
  assign code_b = adc_word_i[1][$bits(conv_pkg::adc_word_t)-1:conv_pkg::ADC_DROP_LSB];

  //////////////////////////////////////////////////////////////////////
  // Capture register
  //////////////////////////////////////////////////////////////////////

  // Negative slope to two's complement
  // MSB stays, the 13 lower bits flip
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      adc_q <= '0;  // Zero sample out of reset
    end else begin
      adc_q.a <= {code_a[13], ~code_a[12:0]};
      adc_q.b <= {code_b[13], ~code_b[12:0]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Loopback select
  //////////////////////////////////////////////////////////////////////

  // Lane results bypass the converters, no added delay
  assign adc_pair_o = loop_en_i ? loop_pair_i : adc_q;

endmodule

//--- logic/analog_path_top.sv
// Analog sample path top, ADC capture, per-channel output lanes and DAC interleaving
`timescale 1ns/1ns

module analog_path_top (
  input  logic                         adc_clk,
  input  logic                         adc_rstn,
  // ADC
  input  conv_pkg::adc_word_t [1:0]    adc_word_i,  // Raw converter words
  // Lane sources
  input  conv_pkg::ch_pair_t           gen_i,       // Generator samples
  input  conv_pkg::ch_pair_t           ctrl_i,      // Controller samples
  // Configuration
  input  logic                         loop_en_i,   // Digital loopback
  input  logic [dsp_pkg::N_CH-1:0]     avg_en_i,    // Boxcar enable per channel
  // Observation and DAC
  output conv_pkg::ch_pair_t           adc_dat_o,   // Captured ADC samples
  output conv_pkg::dac_code_t          dac_dat_o,   // Combined DAC data
  output logic                         dac_sel_o    // DAC channel select
);

  //////////////////////////////////////////////////////////////////////
  // Local wiring
  //////////////////////////////////////////////////////////////////////

  dsp_pkg::lane_in_t [dsp_pkg::N_CH-1:0] lane_in;   // Per channel inputs
  dsp_pkg::sample_t  [dsp_pkg::N_CH-1:0] lane_res;  // Per channel results
  conv_pkg::ch_pair_t                    lane_pair;

  assign lane_in[0] = '{gen: gen_i.a, ctrl: ctrl_i.a};  // Channel A
  assign lane_in[1] = '{gen: gen_i.b, ctrl: ctrl_i.b};  // Channel B

  assign lane_pair = '{a: lane_res[0], b: lane_res[1]};

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////

  adc_frontend adc_frontend_inst (
    .adc_clk     (adc_clk   ),
    .adc_rstn    (adc_rstn  ),
    .adc_word_i  (adc_word_i),
    .loop_en_i   (loop_en_i ),
    .loop_pair_i (lane_pair ),  // Loopback source
    .adc_pair_o  (adc_dat_o )
  );

  for (genvar ch = 0; ch < dsp_pkg::N_CH; ch++) begin : g_lane
    output_lane output_lane_inst (
      .adc_clk  (adc_clk     ),
      .adc_rstn (adc_rstn    ),
      .lane_i   (lane_in[ch] ),
      .avg_en_i (avg_en_i[ch]),
      .result_o (lane_res[ch])
    );
  end

  dac_interleaver dac_interleaver_inst (
    .adc_clk     (adc_clk  ),
    .adc_rstn    (adc_rstn ),
    .lane_pair_i (lane_pair),
    .dac_dat_o   (dac_dat_o),
    .dac_sel_o   (dac_sel_o)
  );

endmodule

//--- logic/conv_pkg.sv
// Converter package with ADC and DAC pin word formats and the channel pair type
package conv_pkg;

  //////////////////////////////////////////////////////////////////////
  // Pin formats
  //////////////////////////////////////////////////////////////////////

  typedef logic [16-1:0] adc_word_t;  // Raw ADC word, code in top 14 bits
  typedef logic [14-1:0] dac_code_t;  // Negative-slope offset code

  // Reserved low bits of the 16 bit converter word
  localparam int ADC_DROP_LSB = 2;

  // Channel pair crossing module boundaries
  // Field a is channel A (converter 0), b is channel B (converter 1)
  typedef struct packed {
    dsp_pkg::sample_t a;
    dsp_pkg::sample_t b;
  } ch_pair_t;

endpackage

//--- logic/dac_interleaver.sv
// DAC interleaver, converts both channels to offset code and time-shares one DAC bus
`timescale 1ns/1ns

module dac_interleaver (
  input  logic                adc_clk,
  input  logic                adc_rstn,
  input  conv_pkg::ch_pair_t  lane_pair_i,  // Lane results, A and B
  output conv_pkg::dac_code_t dac_dat_o,    // Combined DAC data
  output logic                dac_sel_o     // 1 = channel A on the bus
);

  //////////////////////////////////////////////////////////////////////
  // Two's complement to negative-slope code
  //////////////////////////////////////////////////////////////////////

  conv_pkg::dac_code_t code_a;
  conv_pkg::dac_code_t code_b;

  assign code_a = {lane_pair_i.a[13], ~lane_pair_i.a[12:0]};  // MSB kept
  assign code_b = {lane_pair_i.b[13], ~lane_pair_i.b[12:0]};

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  // Select toggles each clock, data follows the new select
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= 14'h1FFF;  // Code of a zero sample
    end else begin
      dac_sel_o <= ~dac_sel_o;
      dac_dat_o <= ~dac_sel_o ? code_a : code_b;  // A goes out with sel high
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // DAC expects a strict A/B alternation once out of reset
  assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    $past(adc_rstn) |-> (dac_sel_o != $past(dac_sel_o)))
    else $error("dac_interleaver: select did not toggle");

endmodule

//--- logic/dsp_pkg.sv
// Sample arithmetic package with stream types, window constants and lane inputs
package dsp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Stream widths
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [14-1:0] sample_t;  // Design stream, two's complement
  typedef logic signed [15-1:0] sum_t;     // Unclamped gen + ctrl
  typedef logic signed [20-1:0] acc_t;     // Window sum, 64 x 14 bit fits exactly

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  localparam int AVG_LOG2 = 6;              // Window exponent
  localparam int AVG_LEN  = 1 << AVG_LOG2;  // 64 samples
  localparam int N_CH     = 2;              // Output channels A and B

  // Clamp limits of the 14 bit range
  localparam sample_t SAMPLE_MAX = 14'h1FFF;
  localparam sample_t SAMPLE_MIN = 14'h2000;

  // One channel's inputs, generator plus controller
  typedef struct packed {
    sample_t gen;   // Generator sample
    sample_t ctrl;  // Controller sample
  } lane_in_t;

endpackage

//--- logic/output_lane.sv
// Output lane with saturating sum of generator and controller plus 64-tap boxcar mean
`timescale 1ns/1ns

module output_lane (
  input  logic              adc_clk,
  input  logic              adc_rstn,
  input  dsp_pkg::lane_in_t lane_i,
  input  logic              avg_en_i,   // 1 selects the windowed mean
  output dsp_pkg::sample_t  result_o
);

  //////////////////////////////////////////////////////////////////////
  // Saturating sum
  //////////////////////////////////////////////////////////////////////

  dsp_pkg::sum_t    sum;   // One guard bit
  dsp_pkg::sample_t sat;   // Clamped to 14 bits

  // Sign extend both, then add
  assign sum = dsp_pkg::sum_t'(lane_i.gen) + dsp_pkg::sum_t'(lane_i.ctrl);

  always_comb begin
    if (sum[14] != sum[13]) begin  // Overflow when top two bits differ
      sat = sum[14] ? dsp_pkg::SAMPLE_MIN : dsp_pkg::SAMPLE_MAX;
    end else begin
      sat = sum[13:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Boxcar window
  //////////////////////////////////////////////////////////////////////

  dsp_pkg::sample_t            hist [dsp_pkg::AVG_LEN];  // Last 64 clamped sums
  logic [dsp_pkg::AVG_LOG2:0]  idx;                      // Oldest entry, next to overwrite
  dsp_pkg::acc_t               acc;                      // Running window sum
  dsp_pkg::acc_t               acc_nxt;
  dsp_pkg::sample_t            mean;

  // New sample in, the one from 64 samples back out
  assign acc_nxt = acc + dsp_pkg::acc_t'(sat)
                   - dsp_pkg::acc_t'(hist[idx[dsp_pkg::AVG_LOG2-1:0]]);

  // Divide by 64, keeps the sign
  assign mean = dsp_pkg::sample_t'(acc_nxt >>> dsp_pkg::AVG_LOG2);

  // Window keeps running in both modes
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      idx      <= '0;
      acc      <= '0;
      result_o <= '0;
      for (int k = 0; k < dsp_pkg::AVG_LEN; k++) begin
        hist[k] <= '0;  // Empty window sums to zero
      end
    end else begin
      hist[idx[dsp_pkg::AVG_LOG2-1:0]] <= sat;  // Replace oldest
      acc       <= acc_nxt;
      if (idx == dsp_pkg::AVG_LEN - 1) begin
        idx <= '0;  // Circular wrap
      end else begin
        idx <= idx + 1'b1;
      end
      result_o <= avg_en_i ? mean : sat;  // Mode select
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Running sum stays inside 64 times the clamp limits
  // A drift here means acc and the history went out of step
  assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    (acc <= dsp_pkg::acc_t'(dsp_pkg::AVG_LEN * int'(dsp_pkg::SAMPLE_MAX))) &&
    (acc >= dsp_pkg::acc_t'(dsp_pkg::AVG_LEN * int'(dsp_pkg::SAMPLE_MIN))))
    else $error("output_lane: window sum out of bounds, acc=%h", acc);

  // Circular index never leaves the window
  assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    idx < dsp_pkg::AVG_LEN)
    else $error("output_lane: index out of window, idx=%h", idx);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the analog path testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module analog_path_tb \
  -o analog_path_sim \
  && ./obj_dir/analog_path_sim > sim.log 2>&1
status=$?
cat sim.log 2>/dev/null
[ "$status" -eq 0 ] && [ -f sim.log ] && ! grep -q "SIMULATION FAILED" sim.log \
  && grep -q "SIMULATION PASSED" sim.log \
  || { echo "Run failed, see sim.log"; exit 1; }
echo "Run finished without failures"

//--- sim/analog_path_checker.sv
// Checker for the analog sample path, keeps a reference model and compares DUT outputs
`timescale 1ns/1ns

module analog_path_checker (
  input  logic                         adc_clk,
  input  logic                         adc_rstn,
  input  conv_pkg::adc_word_t [1:0]    adc_word_i,
  input  conv_pkg::ch_pair_t           gen_i,
  input  conv_pkg::ch_pair_t           ctrl_i,
  input  logic                         loop_en_i,
  input  logic [dsp_pkg::N_CH-1:0]     avg_en_i,
  input  conv_pkg::ch_pair_t           adc_dat_i,   // DUT adc_dat_o
  input  conv_pkg::dac_code_t          dac_dat_i,   // DUT dac_dat_o
  input  logic                         dac_sel_i,   // DUT dac_sel_o
  output int                           err_cnt_o,
  output int                           chk_cyc_o    // Compared cycles so far
);

  //////////////////////////////////////////////////////////////////////
  // Model state, as it stands after the last rising edge
  //////////////////////////////////////////////////////////////////////

  dsp_pkg::sample_t    window [dsp_pkg::N_CH][dsp_pkg::AVG_LEN];  // Last 64 sums
  int                  wpos;                  // Slot of the oldest sum
  dsp_pkg::sample_t    m_res [dsp_pkg::N_CH];  // Lane results
  conv_pkg::ch_pair_t  m_adc;                 // Captured ADC samples
  logic                m_sel;
  conv_pkg::dac_code_t m_dat;
  bit                  armed;                 // Set once reset was seen

  initial begin
    err_cnt_o = 0;
    chk_cyc_o = 0;
    armed     = 1'b0;
  end

  // Sum with clamp to the 14 bit range
  function automatic dsp_pkg::sample_t clamp_sum(input dsp_pkg::sample_t x,
                                                 input dsp_pkg::sample_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > 8191) s = 8191;
    else if (s < -8192) s = -8192;
    return dsp_pkg::sample_t'(s);
  endfunction

  // MSB kept, lower 13 bits inverted
  function automatic conv_pkg::dac_code_t to_dac_code(input dsp_pkg::sample_t s);
    return conv_pkg::dac_code_t'(s) ^ 14'h1FFF;
  endfunction

  function automatic dsp_pkg::sample_t adc_to_sample(input conv_pkg::adc_word_t w);
    return dsp_pkg::sample_t'(w[15:2] ^ 14'h1FFF);  // Reserved LSBs dropped
  endfunction

  // Full window sum every time, floor division by 64
  function automatic dsp_pkg::sample_t window_mean(input int ch);
    int total;
    total = 0;
    for (int k = 0; k < dsp_pkg::AVG_LEN; k++) total += int'(window[ch][k]);
    return dsp_pkg::sample_t'(total >>> 6);
  endfunction

  task automatic expect_equal(input string name, input logic [13:0] got,
                              input logic [13:0] exp);
    if (got !== exp) begin
      $display("ERROR %s at %0t ns: got %h, expected %h", name, $time, got, exp);
      err_cnt_o++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare on the falling edge, then step the model
  //////////////////////////////////////////////////////////////////////

  always @(negedge adc_clk) begin : step_model
    dsp_pkg::sample_t   sat;
    dsp_pkg::sample_t   g;
    dsp_pkg::sample_t   c;
    conv_pkg::ch_pair_t exp_adc;
    if (armed) begin
      chk_cyc_o++;
      if (loop_en_i) begin
        exp_adc.a = m_res[0];  // Loopback, no added delay
        exp_adc.b = m_res[1];
      end else begin
        exp_adc = m_adc;
      end
      expect_equal("adc_dat_o.a", adc_dat_i.a, exp_adc.a);
      expect_equal("adc_dat_o.b", adc_dat_i.b, exp_adc.b);
      expect_equal("dac_dat_o", dac_dat_i, m_dat);
      expect_equal("dac_sel_o", {13'b0, dac_sel_i}, {13'b0, m_sel});
    end
    // Inputs seen now are taken at the next rising edge
    if (adc_rstn === 1'b0) begin
      for (int ch = 0; ch < dsp_pkg::N_CH; ch++) begin
        for (int k = 0; k < dsp_pkg::AVG_LEN; k++) window[ch][k] = '0;
        m_res[ch] = '0;
      end
      wpos  = 0;
      m_adc = '0;
      m_sel = 1'b0;
      m_dat = 14'h1FFF;  // Code of zero
      armed = 1'b1;
    end else if (armed) begin
      // New select high carries channel A
      m_dat = !m_sel ? to_dac_code(m_res[0]) : to_dac_code(m_res[1]);
      m_sel = !m_sel;
      m_adc.a = adc_to_sample(adc_word_i[0]);
      m_adc.b = adc_to_sample(adc_word_i[1]);
      for (int ch = 0; ch < dsp_pkg::N_CH; ch++) begin
        g   = (ch == 0) ? gen_i.a : gen_i.b;
        c   = (ch == 0) ? ctrl_i.a : ctrl_i.b;
        sat = clamp_sum(g, c);
        window[ch][wpos] = sat;  // Oldest out, newest in
        m_res[ch] = avg_en_i[ch] ? window_mean(ch) : sat;
      end
      wpos = (wpos + 1) % dsp_pkg::AVG_LEN;
    end
  end

endmodule

//--- sim/analog_path_tb.sv
// Testbench top for the analog sample path, applies a stimulus table to the DUT
`timescale 1ns/1ns

module analog_path_tb;

  localparam int N_ROWS        = 8;
  localparam int RESET_TIMEOUT = 20;  // Cycles
  localparam int DRAIN_TIMEOUT = 20;
  localparam int PIPE_CHECKS   = 3;   // Compares until the last input shows on the DAC

  typedef enum logic [1:0] {FIXED_VALUES, RAND_SMALL, RAND_FULL} stim_kind_t;

  // One table row
  typedef struct packed {
    logic                loop_en;
    logic [1:0]          avg_en;
    stim_kind_t          kind;
    logic [7:0]          count;     // Stimulus cycles
    dsp_pkg::sample_t    gen_a;
    dsp_pkg::sample_t    ctrl_a;
    dsp_pkg::sample_t    gen_b;
    dsp_pkg::sample_t    ctrl_b;
    conv_pkg::adc_word_t adc_word;  // Channel B gets the inverse
  } row_t;

  logic                        adc_clk;
  logic                        adc_rstn;
  conv_pkg::adc_word_t [1:0]   adc_word;
  conv_pkg::ch_pair_t          gen;
  conv_pkg::ch_pair_t          ctrl;
  logic                        loop_en;
  logic [dsp_pkg::N_CH-1:0]    avg_en;
  conv_pkg::ch_pair_t          adc_dat;
  conv_pkg::dac_code_t         dac_dat;
  logic                        dac_sel;
  int                          err_cnt;
  int                          chk_cyc;

  row_t        rows [N_ROWS];
  string       test_name [N_ROWS];
  logic [31:0] rng;
  bit          timed_out;
  int          tests_run;
  int          tests_failed;

  tb_clock tb_clock_inst (.adc_clk_o(adc_clk), .adc_rstn_o(adc_rstn));

  analog_path_top analog_path_top_inst (
    .adc_clk    (adc_clk ),
    .adc_rstn   (adc_rstn),
    .adc_word_i (adc_word),
    .gen_i      (gen     ),
    .ctrl_i     (ctrl    ),
    .loop_en_i  (loop_en ),
    .avg_en_i   (avg_en  ),
    .adc_dat_o  (adc_dat ),
    .dac_dat_o  (dac_dat ),
    .dac_sel_o  (dac_sel )
  );

  analog_path_checker analog_path_checker_inst (
    .adc_clk    (adc_clk ),
    .adc_rstn   (adc_rstn),
    .adc_word_i (adc_word),
    .gen_i      (gen     ),
    .ctrl_i     (ctrl    ),
    .loop_en_i  (loop_en ),
    .avg_en_i   (avg_en  ),
    .adc_dat_i  (adc_dat ),
    .dac_dat_i  (dac_dat ),
    .dac_sel_i  (dac_sel ),
    .err_cnt_o  (err_cnt ),
    .chk_cyc_o  (chk_cyc )
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Drive one cycle of a row, called right after a rising edge
  task automatic apply_row(input row_t row);
    logic [31:0] r_gen;
    logic [31:0] r_ctrl;
    loop_en <= row.loop_en;
    avg_en  <= row.avg_en;
    if (row.kind == FIXED_VALUES) begin
      adc_word <= {~row.adc_word, row.adc_word};
      gen      <= '{a: row.gen_a, b: row.gen_b};
      ctrl     <= '{a: row.ctrl_a, b: row.ctrl_b};
    end else begin
      rng = xorshift32(rng);
      adc_word <= rng;
      rng = xorshift32(rng);
      r_gen = rng;
      rng = xorshift32(rng);
      r_ctrl = rng;
      if (row.kind == RAND_SMALL) begin
        // 13 bit values, the sum never leaves the range
        gen  <= '{a: {r_gen[12], r_gen[12:0]}, b: {r_gen[28], r_gen[28:16]}};
        ctrl <= '{a: {r_ctrl[12], r_ctrl[12:0]}, b: {r_ctrl[28], r_ctrl[28:16]}};
      end else begin
        gen  <= '{a: r_gen[13:0], b: r_gen[29:16]};
        ctrl <= '{a: r_ctrl[13:0], b: r_ctrl[29:16]};
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table and test loop
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    int wait_n;
    int target;
    int err_start;
    adc_word     = '0;
    gen          = '0;
    ctrl         = '0;
    loop_en      = 1'b0;
    avg_en       = '0;
    rng          = 32'h4e02;
    timed_out    = 1'b0;
    tests_run    = 0;
    tests_failed = 0;

    // loop_en, avg_en, kind, count, gen_a, ctrl_a, gen_b, ctrl_b, adc_word
    rows[0] = '{1'b0, 2'b00, FIXED_VALUES, 8'd4, 14'h0, 14'h0, 14'h0, 14'h0, 16'h0};
    rows[1] = '{1'b0, 2'b00, RAND_FULL, 8'd40, 14'h0, 14'h0, 14'h0, 14'h0, 16'h0};
    rows[2] = '{1'b0, 2'b00, RAND_SMALL, 8'd40, 14'h0, 14'h0, 14'h0, 14'h0, 16'h0};
    rows[3] = '{1'b0, 2'b00, FIXED_VALUES, 8'd8,
                14'h1800, 14'h1000, 14'h2000, 14'h3000, 16'h8003};  // A high, B low
    rows[4] = '{1'b0, 2'b00, RAND_FULL, 8'd40, 14'h0, 14'h0, 14'h0, 14'h0, 16'h0};
    rows[5] = '{1'b0, 2'b01, FIXED_VALUES, 8'd70,
                14'h0123, 14'h0100, 14'h0F00, 14'h3F00, 16'h5a5c};  // Held constant
    rows[6] = '{1'b0, 2'b01, RAND_FULL, 8'd100, 14'h0, 14'h0, 14'h0, 14'h0, 16'h0};
    rows[7] = '{1'b1, 2'b10, RAND_SMALL, 8'd40, 14'h0, 14'h0, 14'h0, 14'h0, 16'h0};
    test_name = '{"reset_idle", "adc_convert", "direct_sum", "saturate_fixed",
                  "saturate_rand", "avg_const", "avg_rand", "loopback"};

    wait_n = 0;
    while (adc_rstn !== 1'b1 && wait_n < RESET_TIMEOUT) begin
      @(posedge adc_clk);
      wait_n++;
    end
    if (adc_rstn !== 1'b1) begin
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
      timed_out = 1'b1;
    end

    for (int r = 0; r < N_ROWS && !timed_out; r++) begin
      err_start = err_cnt;
      for (int n = 0; n < int'(rows[r].count); n++) begin
        @(posedge adc_clk);
        apply_row(rows[r]);
      end
      // Inputs hold while the pipeline drains into the checker
      target = chk_cyc + PIPE_CHECKS;
      wait_n = 0;
      while (chk_cyc < target && wait_n < DRAIN_TIMEOUT) begin
        @(posedge adc_clk);
        wait_n++;
      end
      if (chk_cyc < target) begin
        $display("Test %s: checker did not finish within %0d cycles", test_name[r],
                 DRAIN_TIMEOUT);
        timed_out = 1'b1;
      end else begin
        tests_run++;
        if (err_cnt != err_start) tests_failed++;
        $display("Test %0d %s: %s, %0d errors", r, test_name[r],
                 (err_cnt == err_start) ? "pass" : "fail", err_cnt - err_start);
      end
    end

    $display("Tests run %0d, failed %0d, compared cycles %0d, errors %0d",
             tests_run, tests_failed, chk_cyc, err_cnt);
    if (timed_out || err_cnt != 0) begin
      $display("SIMULATION FAILED");
    end else begin
      $display("SIMULATION PASSED");
    end
    $finish;
  end

endmodule

//--- sim/tb_clock.sv
// Clock and reset generator for the analog path testbench
`timescale 1ns/1ns

module tb_clock (
  output logic adc_clk_o,
  output logic adc_rstn_o
);

  localparam int HALF_PERIOD_NS = 50;  // 100 ns period
  localparam int RESET_CYCLES   = 2;

  initial begin
    adc_clk_o = 1'b0;
    forever #HALF_PERIOD_NS adc_clk_o = ~adc_clk_o;
  end

  // Low across two rising edges, released on the second
  initial begin
    adc_rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge adc_clk_o);
    adc_rstn_o <= 1'b1;
  end

endmodule

//--- verilog.f
logic/dsp_pkg.sv
logic/conv_pkg.sv
logic/adc_frontend.sv
logic/output_lane.sv
logic/dac_interleaver.sv
logic/analog_path_top.sv
sim/tb_clock.sv
sim/analog_path_checker.sv
sim/analog_path_tb.sv
